//--- common/scope_pkg.sv
package scope_pkg;

   // Sample path
   localparam int SAMPLE_W  = 10;
   localparam int RAM_DEPTH = 256;
   localparam int ADDR_W    = $clog2(RAM_DEPTH);
   localparam int LEN_W     = ADDR_W + 1;

   // Readout flow control
   localparam int CREDIT_MAX = 4;
   localparam int CREDIT_W   = $clog2(CREDIT_MAX + 1);

   typedef logic signed [SAMPLE_W-1:0] sample_t;
   typedef logic [ADDR_W-1:0]          addr_t;
   typedef logic [LEN_W-1:0]           len_t;
   typedef logic [2:0]                 ds_shift_t;
   typedef logic [15:0]                cmd_arg_t;
   typedef logic [CREDIT_W-1:0]        credit_t;
   typedef logic [15:0]                event_t;

   // Configuration after reset
   localparam sample_t   DEF_LOWER = -64;
   localparam sample_t   DEF_UPPER = 64;
   localparam len_t      DEF_PRE   = 16;
   localparam len_t      DEF_POST  = 48;
   localparam ds_shift_t DEF_DS    = 0;

   typedef enum logic [2:0] {
      CMD_NOP       = 3'd0,
      CMD_SET_LOWER = 3'd1,
      CMD_SET_UPPER = 3'd2,
      CMD_SET_PRE   = 3'd3,
      CMD_SET_POST  = 3'd4,
      CMD_SET_DS    = 3'd5,
      CMD_ARM       = 3'd6
   } cmd_op_t;

   typedef enum logic [2:0] {
      TRIG_IDLE  = 3'd0,
      TRIG_PRE   = 3'd1,
      TRIG_ARMED = 3'd2,
      TRIG_POST  = 3'd3,
      TRIG_DONE  = 3'd4
   } trig_state_t;

endpackage

//--- acquisition/sample_capture.sv
`timescale 1ns/1ps

module sample_capture (
   input  logic                  lvds_clk_slow_clkin,
   input  logic                  rst_n,
   input  scope_pkg::sample_t    lvds_rx_data,
   input  scope_pkg::ds_shift_t  ds_shift,
   output scope_pkg::sample_t    sample,
   output logic                  sample_valid
);

   logic [6:0] ds_cnt;
   logic [6:0] keep_mask;
   logic       keep;

   // Low ds_shift bits of the counter select one word in 2**ds_shift
   assign keep_mask = (7'd1 << ds_shift) - 7'd1;
   assign keep      = (ds_cnt & keep_mask) == 7'd0;

   always_ff @(posedge lvds_clk_slow_clkin) begin
      if (!rst_n) begin
         ds_cnt       <= '0;
         sample_valid <= 1'b0;
      end else begin
         ds_cnt       <= ds_cnt + 7'd1;
         sample_valid <= keep;
      end
   end

   // LVDS word register
   always_ff @(posedge lvds_clk_slow_clkin) begin
      if (keep) begin
         sample <= lvds_rx_data;
      end
   end

endmodule

//--- acquisition/edge_trigger.sv
`timescale 1ns/1ps

module edge_trigger (
   input  logic                    lvds_clk_slow_clkin,
   input  logic                    rst_n,
   input  scope_pkg::sample_t      sample,
   input  logic                    sample_valid,
   input  logic                    arm,
   input  scope_pkg::sample_t      lower,
   input  scope_pkg::sample_t      upper,
   input  scope_pkg::len_t         pre_len,
   input  scope_pkg::len_t         post_len,
   input  logic                    readout_done,
   output logic                    ram_wr,
   output scope_pkg::addr_t        ram_wr_addr,
   output scope_pkg::sample_t      ram_wr_data,
   output scope_pkg::trig_state_t  acq_state,
   output scope_pkg::event_t       event_count,
   output logic                    capture_ready,
   output scope_pkg::addr_t        capture_start
);

   scope_pkg::addr_t wr_ptr;
   scope_pkg::addr_t trig_addr;
   scope_pkg::len_t  pre_cnt;
   scope_pkg::len_t  post_cnt;
   logic             primed;
   logic             hit;

   // The ring holds still while a window waits for readout
   assign ram_wr      = sample_valid && (acq_state != scope_pkg::TRIG_DONE);
   assign ram_wr_addr = wr_ptr;
   assign ram_wr_data = sample;

   // Hysteresis: only a sample after priming can fire
   assign hit = sample_valid && primed && (sample >= upper);

   always_ff @(posedge lvds_clk_slow_clkin) begin
      if (!rst_n) begin
         acq_state     <= scope_pkg::TRIG_IDLE;
         wr_ptr        <= '0;
         pre_cnt       <= '0;
         post_cnt      <= '0;
         primed        <= 1'b0;
         event_count   <= '0;
         capture_ready <= 1'b0;
      end else begin
         capture_ready <= 1'b0;
         if (ram_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         case (acq_state)
            scope_pkg::TRIG_IDLE: begin
               if (arm) begin
                  pre_cnt   <= '0;
                  primed    <= 1'b0;
                  acq_state <= (pre_len == '0) ? scope_pkg::TRIG_ARMED : scope_pkg::TRIG_PRE;
               end
            end
            scope_pkg::TRIG_PRE: begin
               if (sample_valid) begin
                  pre_cnt <= pre_cnt + 1'b1;
                  if (pre_cnt + 1'b1 == pre_len) begin
                     acq_state <= scope_pkg::TRIG_ARMED;
                  end
               end
            end
            scope_pkg::TRIG_ARMED: begin
               if (hit) begin
                  // Trigger sample counts as post sample one
                  trig_addr   <= wr_ptr;
                  post_cnt    <= scope_pkg::len_t'(1);
                  event_count <= event_count + 1'b1;
                  if (post_len <= scope_pkg::len_t'(1)) begin
                     acq_state     <= scope_pkg::TRIG_DONE;
                     capture_ready <= 1'b1;
                     capture_start <= wr_ptr - scope_pkg::addr_t'(pre_len);
                  end else begin
                     acq_state <= scope_pkg::TRIG_POST;
                  end
               end else if (sample_valid && (sample <= lower)) begin
                  primed <= 1'b1;
               end
            end
            scope_pkg::TRIG_POST: begin
               if (sample_valid) begin
                  post_cnt <= post_cnt + 1'b1;
                  if (post_cnt + 1'b1 == post_len) begin
                     acq_state     <= scope_pkg::TRIG_DONE;
                     capture_ready <= 1'b1;
                     capture_start <= trig_addr - scope_pkg::addr_t'(pre_len);
                  end
               end
            end
            scope_pkg::TRIG_DONE: begin
               if (readout_done) begin
                  acq_state <= scope_pkg::TRIG_IDLE;
               end
            end
            default: acq_state <= scope_pkg::TRIG_IDLE;
         endcase
      end
   end

endmodule

//--- acquisition/sample_ram.sv
`timescale 1ns/1ps

module sample_ram (
   input  logic                lvds_clk_slow_clkin,
   input  logic                wr_en,
   input  scope_pkg::addr_t    wr_addr,
   input  scope_pkg::sample_t  wr_data,
   input  logic                rd_en,
   input  scope_pkg::addr_t    rd_addr,
   output scope_pkg::sample_t  rd_data
);

   scope_pkg::sample_t mem [scope_pkg::RAM_DEPTH];

   always_ff @(posedge lvds_clk_slow_clkin) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
      // Read port is registered, data one cycle after rd_en
      if (rd_en) begin
         rd_data <= mem[rd_addr];
      end
   end

endmodule

//--- readout/readout_streamer.sv
`timescale 1ns/1ps

module readout_streamer (
   input  logic                lvds_clk_slow_clkin,
   input  logic                rst_n,
   input  logic                capture_ready,
   input  scope_pkg::addr_t    capture_start,
   input  scope_pkg::len_t     pre_len,
   input  scope_pkg::len_t     post_len,
   input  scope_pkg::sample_t  rd_data,
   input  logic                credit_return,
   output logic                rd_en,
   output scope_pkg::addr_t    rd_addr,
   output logic                out_valid,
   output scope_pkg::sample_t  out_data,
   output logic                out_last,
   output logic                readout_done
);

   logic [scope_pkg::LEN_W:0] issue_left;
   scope_pkg::credit_t        credits;
   scope_pkg::credit_t        in_flight;
   logic                      rd_vld;
   logic                      rd_last;

   // A read goes out only if a credit is already set aside for its word
   assign rd_en = (issue_left != '0) && (credits > in_flight);

   always_ff @(posedge lvds_clk_slow_clkin) begin
      if (!rst_n) begin
         issue_left   <= '0;
         credits      <= scope_pkg::credit_t'(scope_pkg::CREDIT_MAX);
         in_flight    <= '0;
         rd_vld       <= 1'b0;
         rd_last      <= 1'b0;
         out_valid    <= 1'b0;
         out_last     <= 1'b0;
         readout_done <= 1'b0;
      end else begin
         if (capture_ready) begin
            rd_addr    <= capture_start;
            issue_left <= pre_len + post_len;
         end else if (rd_en) begin
            rd_addr    <= rd_addr + 1'b1;
            issue_left <= issue_left - 1'b1;
         end
         // Two-stage return path, RAM read then output register
         rd_vld       <= rd_en;
         rd_last      <= rd_en && (issue_left == 1);
         out_valid    <= rd_vld;
         out_last     <= rd_last;
         readout_done <= out_valid && out_last;
         in_flight    <= in_flight + rd_en - out_valid;
         // Saturate so stray returns cannot overflow the count
         if (credit_return && !out_valid) begin
            if (credits != scope_pkg::credit_t'(scope_pkg::CREDIT_MAX))
               credits <= credits + 1'b1;
         end else if (out_valid && !credit_return) begin
            credits <= credits - 1'b1;
         end
      end
   end

   always_ff @(posedge lvds_clk_slow_clkin) begin
      if (rd_vld) begin
         out_data <= rd_data;
      end
   end

endmodule

//--- hdl/scope_regs.sv
`timescale 1ns/1ps

module scope_regs (
   input  logic                    lvds_clk_slow_clkin,
   input  logic                    rst_n,
   input  logic                    cmd_valid,
   input  scope_pkg::cmd_op_t      cmd_op,
   input  scope_pkg::cmd_arg_t     cmd_arg,
   input  scope_pkg::trig_state_t  acq_state,
   output scope_pkg::sample_t      lower,
   output scope_pkg::sample_t      upper,
   output scope_pkg::len_t         pre_len,
   output scope_pkg::len_t         post_len,
   output scope_pkg::ds_shift_t    ds_shift,
   output logic                    arm
);

   // Window lengths never exceed the ring size
   function automatic scope_pkg::len_t clamp_len(input scope_pkg::cmd_arg_t arg);
      if (arg > scope_pkg::cmd_arg_t'(scope_pkg::RAM_DEPTH))
         return scope_pkg::len_t'(scope_pkg::RAM_DEPTH);
      return scope_pkg::len_t'(arg);
   endfunction

   logic cfg_open;

   // Configuration only changes between acquisitions
   assign cfg_open = cmd_valid && (acq_state == scope_pkg::TRIG_IDLE);

   always_ff @(posedge lvds_clk_slow_clkin) begin
      if (!rst_n) begin
         lower    <= scope_pkg::DEF_LOWER;
         upper    <= scope_pkg::DEF_UPPER;
         pre_len  <= scope_pkg::DEF_PRE;
         post_len <= scope_pkg::DEF_POST;
         ds_shift <= scope_pkg::DEF_DS;
         arm      <= 1'b0;
      end else begin
         arm <= cmd_valid && (cmd_op == scope_pkg::CMD_ARM);
         if (cfg_open) begin
            case (cmd_op)
               scope_pkg::CMD_SET_LOWER: lower    <= cmd_arg[scope_pkg::SAMPLE_W-1:0];
               scope_pkg::CMD_SET_UPPER: upper    <= cmd_arg[scope_pkg::SAMPLE_W-1:0];
               scope_pkg::CMD_SET_PRE:   pre_len  <= clamp_len(cmd_arg);
               scope_pkg::CMD_SET_POST:  post_len <= clamp_len(cmd_arg);
               scope_pkg::CMD_SET_DS:    ds_shift <= cmd_arg[2:0];
               default: ;
            endcase
         end
      end
   end

endmodule

//--- hdl/scope_top.sv
`timescale 1ns/1ps

module scope_top (
   input  logic                    lvds_clk_slow_clkin,
   input  logic                    rst_n,
   input  scope_pkg::sample_t      lvds_rx_data,
   input  logic                    cmd_valid,
   input  scope_pkg::cmd_op_t      cmd_op,
   input  scope_pkg::cmd_arg_t     cmd_arg,
   input  logic                    credit_return,
   output logic                    out_valid,
   output scope_pkg::sample_t      out_data,
   output logic                    out_last,
   output scope_pkg::trig_state_t  acq_state,
   output scope_pkg::event_t       event_count
);

   // Configuration from the command port
   scope_pkg::sample_t   lower;
   scope_pkg::sample_t   upper;
   scope_pkg::len_t      pre_len;
   scope_pkg::len_t      post_len;
   scope_pkg::ds_shift_t ds_shift;
   logic                 arm;

   // Decimated sample stream
   scope_pkg::sample_t   sample;
   logic                 sample_valid;

   // RAM write and read sides
   logic                 ram_wr;
   scope_pkg::addr_t     ram_wr_addr;
   scope_pkg::sample_t   ram_wr_data;
   logic                 rd_en;
   scope_pkg::addr_t     rd_addr;
   scope_pkg::sample_t   rd_data;

   // Trigger to readout handoff
   logic                 capture_ready;
   scope_pkg::addr_t     capture_start;
   logic                 readout_done;

   scope_regs u_regs (
      .lvds_clk_slow_clkin(lvds_clk_slow_clkin),
      .rst_n(rst_n),
      .cmd_valid(cmd_valid),
      .cmd_op(cmd_op),
      .cmd_arg(cmd_arg),
      .acq_state(acq_state),
      .lower(lower),
      .upper(upper),
      .pre_len(pre_len),
      .post_len(post_len),
      .ds_shift(ds_shift),
      .arm(arm)
   );

   sample_capture u_capture (
      .lvds_clk_slow_clkin(lvds_clk_slow_clkin),
      .rst_n(rst_n),
      .lvds_rx_data(lvds_rx_data),
      .ds_shift(ds_shift),
      .sample(sample),
      .sample_valid(sample_valid)
   );

   edge_trigger u_trigger (
      .lvds_clk_slow_clkin(lvds_clk_slow_clkin),
      .rst_n(rst_n),
      .sample(sample),
      .sample_valid(sample_valid),
      .arm(arm),
      .lower(lower),
      .upper(upper),
      .pre_len(pre_len),
      .post_len(post_len),
      .readout_done(readout_done),
      .ram_wr(ram_wr),
      .ram_wr_addr(ram_wr_addr),
      .ram_wr_data(ram_wr_data),
      .acq_state(acq_state),
      .event_count(event_count),
      .capture_ready(capture_ready),
      .capture_start(capture_start)
   );

   sample_ram u_ram (
      .lvds_clk_slow_clkin(lvds_clk_slow_clkin),
      .wr_en(ram_wr),
      .wr_addr(ram_wr_addr),
      .wr_data(ram_wr_data),
      .rd_en(rd_en),
      .rd_addr(rd_addr),
      .rd_data(rd_data)
   );

   readout_streamer u_streamer (
      .lvds_clk_slow_clkin(lvds_clk_slow_clkin),
      .rst_n(rst_n),
      .capture_ready(capture_ready),
      .capture_start(capture_start),
      .pre_len(pre_len),
      .post_len(post_len),
      .rd_data(rd_data),
      .credit_return(credit_return),
      .rd_en(rd_en),
      .rd_addr(rd_addr),
      .out_valid(out_valid),
      .out_data(out_data),
      .out_last(out_last),
      .readout_done(readout_done)
   );

endmodule

//--- sim/scope_props.sv
`timescale 1ns/1ps

module scope_props #(
   parameter bit STREAM_SIDE = 1'b1
) (
   input logic                   lvds_clk_slow_clkin,
   input logic                   rst_n,
   input logic                   out_valid,
   input logic                   out_last,
   input scope_pkg::credit_t     credits,
   input logic                   capture_ready,
   input scope_pkg::trig_state_t acq_state
);

   if (STREAM_SIDE) begin : g_stream
      // A word on the output always has a credit behind it
      a_credit: assert property (@(posedge lvds_clk_slow_clkin) disable iff (!rst_n)
         out_valid |-> credits != '0)
         else $error("out_valid asserted with zero credits");

      a_last: assert property (@(posedge lvds_clk_slow_clkin) disable iff (!rst_n)
         out_last |-> out_valid)
         else $error("out_last without out_valid");
   end else begin : g_trigger
      a_ready: assert property (@(posedge lvds_clk_slow_clkin) disable iff (!rst_n)
         capture_ready |-> (acq_state == scope_pkg::TRIG_DONE) &&
                           ($past(acq_state) != scope_pkg::TRIG_DONE))
         else $error("capture_ready outside entry to done state");
   end

endmodule

bind readout_streamer scope_props #(.STREAM_SIDE(1'b1)) u_stream_props (
   .lvds_clk_slow_clkin(lvds_clk_slow_clkin),
   .rst_n(rst_n),
   .out_valid(out_valid),
   .out_last(out_last),
   .credits(credits),
   .capture_ready(1'b0),
   .acq_state(scope_pkg::TRIG_IDLE)
);

bind edge_trigger scope_props #(.STREAM_SIDE(1'b0)) u_trig_props (
   .lvds_clk_slow_clkin(lvds_clk_slow_clkin),
   .rst_n(rst_n),
   .out_valid(1'b0),
   .out_last(1'b0),
   .credits(scope_pkg::credit_t'(scope_pkg::CREDIT_MAX)),
   .capture_ready(capture_ready),
   .acq_state(acq_state)
);

//--- sim/scope_tb.sv
`timescale 1ns/1ps

module scope_tb;

   logic                   clk;
   logic                   rst_n = 1'b0;
   scope_pkg::sample_t     lvds_rx_data = '0;
   logic                   cmd_valid;
   scope_pkg::cmd_op_t     cmd_op;
   scope_pkg::cmd_arg_t    cmd_arg;
   logic                   credit_return = 1'b0;
   logic                   out_valid;
   scope_pkg::sample_t     out_data;
   logic                   out_last;
   scope_pkg::trig_state_t acq_state;
   scope_pkg::event_t      event_count;

   int errors = 0;
   int checks = 0;
   bit timed_out = 1'b0;
   int windows_done = 0;
   int k_cnt = 0;
   int m_ds = 0;
   bit saw_on = 1'b0;
   bit saw_run = 1'b0;
   int saw_n = 0;
   int cur_n = -1;
   int s_base = 0;
   int s_step = 0;
   int s_period = 1;
   int gap_lim = 0;
   int words_seen = 0;
   int credits_given = 0;
   int owed = 0;
   int gap_cnt = 0;
   scope_pkg::sample_t hist_val[$];
   int                 hist_n[$];
   scope_pkg::sample_t rx_val[$];
   bit                 rx_last[$];

   scope_top DUT (
      .lvds_clk_slow_clkin(clk),
      .rst_n(rst_n),
      .lvds_rx_data(lvds_rx_data),
      .cmd_valid(cmd_valid),
      .cmd_op(cmd_op),
      .cmd_arg(cmd_arg),
      .credit_return(credit_return),
      .out_valid(out_valid),
      .out_data(out_data),
      .out_last(out_last),
      .acq_state(acq_state),
      .event_count(event_count)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Decimation model and sawtooth source, n = -1 marks a quiet word
   always @(posedge clk) begin
      int mask;
      mask = (1 << m_ds) - 1;
      if (!rst_n) begin
         k_cnt = 0;
      end else begin
         if ((k_cnt & mask) == 0) begin
            hist_val.push_back(lvds_rx_data);
            hist_n.push_back(cur_n);
         end
         k_cnt = k_cnt + 1;
      end
      if (!saw_on)
         saw_run = 1'b0;
      // Start on a counter boundary so n = 0 is always a kept word
      else if (!saw_run && ((k_cnt & 127) == 0))
         saw_run = 1'b1;
      if (saw_run) begin
         lvds_rx_data <= scope_pkg::sample_t'(s_base + s_step * (saw_n % s_period));
         cur_n = saw_n;
         saw_n = saw_n + 1;
      end else begin
         lvds_rx_data <= '0;
         cur_n = -1;
      end
   end

   // Output capture and credit return with random gaps
   always @(posedge clk) begin
      if (out_valid) begin
         rx_val.push_back(out_data);
         rx_last.push_back(out_last);
         words_seen = words_seen + 1;
         owed = owed + 1;
      end
      if (credit_return)
         credits_given = credits_given + 1;
      if (words_seen > scope_pkg::CREDIT_MAX + credits_given) begin
         errors = errors + 1;
         $display("more words sent than credits allowed: %0d words, %0d returned",
                  words_seen, credits_given);
      end
      credit_return <= 1'b0;
      if (owed > 0) begin
         if (gap_cnt == 0) begin
            credit_return <= 1'b1;
            owed = owed - 1;
            gap_cnt = int'($urandom % (gap_lim + 1));
         end else begin
            gap_cnt = gap_cnt - 1;
         end
      end
   end

   task automatic check_sample(input string name, input scope_pkg::sample_t got,
                               input scope_pkg::sample_t exp);
      checks = checks + 1;
      if (got !== exp) begin
         errors = errors + 1;
         $display("mismatch %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_state(input string name, input scope_pkg::trig_state_t got,
                              input scope_pkg::trig_state_t exp);
      checks = checks + 1;
      if (got !== exp) begin
         errors = errors + 1;
         $display("mismatch %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_count(input string name, input scope_pkg::event_t got,
                              input scope_pkg::event_t exp);
      checks = checks + 1;
      if (got !== exp) begin
         errors = errors + 1;
         $display("mismatch %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic report_timeout(input string what);
      errors = errors + 1;
      timed_out = 1'b1;
      $display("timeout while waiting for %s", what);
   endtask

   task automatic wait_state(input scope_pkg::trig_state_t st, input int limit,
                             input string what);
      int i;
      i = 0;
      while (acq_state != st && i < limit) begin
         @(posedge clk);
         i = i + 1;
      end
      if (acq_state != st)
         report_timeout(what);
   endtask

   task automatic send_cmd(input scope_pkg::cmd_op_t op, input int arg);
      @(posedge clk);
      cmd_valid <= 1'b1;
      cmd_op    <= op;
      cmd_arg   <= scope_pkg::cmd_arg_t'(arg);
      @(posedge clk);
      cmd_valid <= 1'b0;
      cmd_op    <= scope_pkg::CMD_NOP;
   endtask

   task automatic run_scenario(input int ds, input int lo, input int up, input int pre,
                               input int post, input int gap, input int exp_idx);
      int  t;
      int  i;
      int  total;
      bit  primed;
      wait_state(scope_pkg::TRIG_IDLE, 2000, "idle before scenario");
      if (timed_out)
         return;
      gap_lim = gap;
      total = pre + post;
      send_cmd(scope_pkg::CMD_SET_LOWER, lo);
      send_cmd(scope_pkg::CMD_SET_UPPER, up);
      send_cmd(scope_pkg::CMD_SET_PRE, pre);
      send_cmd(scope_pkg::CMD_SET_POST, post);
      send_cmd(scope_pkg::CMD_SET_DS, ds);
      m_ds <= ds;
      @(posedge clk);
      hist_val.delete();
      hist_n.delete();
      rx_val.delete();
      rx_last.delete();
      send_cmd(scope_pkg::CMD_ARM, 0);
      wait_state(scope_pkg::TRIG_ARMED, 5000, "armed state");
      if (timed_out)
         return;
      // Both commands arrive while busy and must have no effect
      send_cmd(scope_pkg::CMD_SET_UPPER, 0);
      send_cmd(scope_pkg::CMD_ARM, 0);
      repeat (2) @(posedge clk);
      check_state("acq_state", acq_state, scope_pkg::TRIG_ARMED);
      saw_n = 0;
      saw_on = 1'b1;
      i = 0;
      while ((rx_val.size() < total || acq_state != scope_pkg::TRIG_IDLE) && i < 40000) begin
         @(posedge clk);
         i = i + 1;
      end
      saw_on = 1'b0;
      if (rx_val.size() < total || acq_state != scope_pkg::TRIG_IDLE) begin
         report_timeout("window readout");
         return;
      end

      // Hysteresis rule applied to the kept sawtooth words
      primed = 1'b0;
      t = -1;
      for (i = 0; i < hist_val.size() && t < 0; i++) begin
         if (hist_n[i] >= 0) begin
            if (primed && hist_val[i] >= scope_pkg::sample_t'(up))
               t = i;
            else if (hist_val[i] <= scope_pkg::sample_t'(lo))
               primed = 1'b1;
         end
      end
      if (t < pre || t + post > hist_val.size()) begin
         errors = errors + 1;
         $display("model found no complete window around a trigger");
      end else begin
         check_count("trigger_index", scope_pkg::event_t'(hist_n[t]),
                     scope_pkg::event_t'(exp_idx));
         check_count("window_len", scope_pkg::event_t'(rx_val.size()),
                     scope_pkg::event_t'(total));
         for (i = 0; i < total && i < rx_val.size(); i++) begin
            check_sample("out_data", rx_val[i], hist_val[t - pre + i]);
            check_count("out_last", scope_pkg::event_t'(rx_last[i]),
                        scope_pkg::event_t'(i == total - 1));
         end
      end
      windows_done = windows_done + 1;
      check_count("event_count", event_count, scope_pkg::event_t'(windows_done));
   endtask

   initial begin
      string line;
      int fd;
      int n;
      int scen;
      int f_ds, f_lo, f_up, f_pre, f_post, f_base, f_step, f_per, f_gap, f_idx;
      void'($urandom(32'h1c1b_9704));
      cmd_valid = 1'b0;
      cmd_op    = scope_pkg::CMD_NOP;
      cmd_arg   = '0;
      scen      = 0;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      @(posedge clk);
      check_state("acq_state", acq_state, scope_pkg::TRIG_IDLE);
      check_count("event_count", event_count, '0);
      repeat (20) @(posedge clk);
      check_count("words_after_reset", scope_pkg::event_t'(words_seen), '0);

      fd = $fopen("sim/scope_input.txt", "r");
      if (fd == 0) begin
         errors = errors + 1;
         $display("cannot open stimulus file sim/scope_input.txt");
      end else begin
         while (!$feof(fd) && !timed_out) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#")
               continue;
            n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d", f_ds, f_lo, f_up, f_pre,
                        f_post, f_base, f_step, f_per, f_gap, f_idx);
            if (n != 10) begin
               errors = errors + 1;
               $display("malformed stimulus line: %s", line);
            end else begin
               s_base = f_base;
               s_step = f_step;
               s_period = f_per;
               run_scenario(f_ds, f_lo, f_up, f_pre, f_post, f_gap, f_idx);
               scen = scen + 1;
            end
         end
         $fclose(fd);
      end
      if (scen == 0) begin
         errors = errors + 1;
         $display("no scenarios were run");
      end

      $display("errors %0d checks %0d scenarios %0d", errors, checks, scen);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

//--- sim/scope_input.txt
# ds lower upper pre post base step period credit_gap trigger_index
# Sawtooth word n is base + step * (n % period), index counts input words
0 -64 64 16 48 -100 8 40 0 21
0 -64 64 8 20 100 -10 30 3 30
2 -100 100 10 30 -200 5 100 2 60
1 -20 40 32 32 50 -3 90 5 90
3 -50 50 4 12 -300 7 110 7 56
0 -64 64 20 40 -80 16 20 12 9
0 -10 10 0 5 -20 4 15 1 8
0 -64 64 16 48 -100 8 40 20 21

//--- sim.f
common/scope_pkg.sv
acquisition/sample_capture.sv
acquisition/edge_trigger.sv
acquisition/sample_ram.sv
readout/readout_streamer.sv
hdl/scope_regs.sv
hdl/scope_top.sv
sim/scope_props.sv
sim/scope_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module scope_tb -f sim.f -o scope_sim
out=$(./obj_dir/scope_sim)
echo "$out"
if echo "$out" | grep -q "Regression passed"; then
   exit 0
fi
exit 1
